/* Bender.yml */
package:
  name: leaf_i4o7

sources:
  - leaf_pkg.sv
  - stream_fifo.sv
  - ingress_demux.sv
  - egress_arbiter.sv
  - user_port_bridge.sv
  - leaf_interface.sv
  - user_kernel.sv
  - leaf_i4o7.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_leaf.sv

/* egress_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module egress_arbiter (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 resend,
    input  wire [leaf_pkg::NUM_OUT_PORTS-1:0]   queue_empty,
    input  leaf_pkg::user_word_t                queue_head [leaf_pkg::NUM_OUT_PORTS],
    input  leaf_pkg::route_t                    route_table [leaf_pkg::NUM_OUT_PORTS],
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]  queue_pop,
    output leaf_pkg::bft_packet_t               dout
);
    import leaf_pkg::*;

    logic [OUT_PORT_BITS-1:0] ptr_q;      // first port to look at
    logic [OUT_PORT_BITS-1:0] grant;
    logic [OUT_PORT_BITS-1:0] next_ptr;
    logic                     grant_vld;
    logic                     fire;

    // scan from the far end so the nearest non-empty queue wins
    always_comb begin : pick
        int idx;
        grant_vld = 1'b0;
        grant     = '0;
        for (int k = NUM_OUT_PORTS - 1; k >= 0; k--) begin
            idx = int'(ptr_q) + k;
            if (idx >= NUM_OUT_PORTS) begin
                idx = idx - NUM_OUT_PORTS;
            end
            if (!queue_empty[idx]) begin
                grant_vld = 1'b1;
                grant     = OUT_PORT_BITS'(idx);
            end
        end
    end

    assign fire     = grant_vld && !resend;
    assign next_ptr = (grant == OUT_PORT_BITS'(NUM_OUT_PORTS - 1)) ? '0 : grant + 1'b1;

    always_comb begin
        queue_pop = '0;
        if (fire) begin
            queue_pop[grant] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr_q <= '0;
            dout  <= '0;
        end else if (!resend) begin   // a registered packet waits out the resend
            dout <= '0;
            if (fire) begin
                ptr_q <= next_ptr;
                if (route_table[grant].en) begin   // unrouted words are dropped here
                    dout <= '{
                        vld:     1'b1,
                        leaf:    route_table[grant].leaf,
                        port:    route_table[grant].port,
                        addr:    NUM_ADDR_BITS'(grant),
                        payload: queue_head[grant]
                    };
                end
            end
        end
    end

endmodule

`default_nettype wire

/* ingress_demux.sv */
`timescale 1ns/1ps
`default_nettype none

module ingress_demux (
    input  wire                                 clk,
    input  wire                                 reset,
    input  leaf_pkg::bft_packet_t               din,
    input  wire [leaf_pkg::NUM_IN_PORTS-1:0]    queue_full,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]   queue_push,
    output leaf_pkg::user_word_t                queue_data,
    output leaf_pkg::route_t                    route_table [leaf_pkg::NUM_OUT_PORTS]
);
    import leaf_pkg::*;

    logic cfg_hit;

    assign queue_data = din.payload;
    assign cfg_hit    = din.vld && (din.port == NUM_PORT_BITS'(CONFIG_PORT))
                        && (din.addr < NUM_ADDR_BITS'(NUM_OUT_PORTS));

    // ports 4 to 14 match nothing and fall through
    always_comb begin
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            queue_push[i] = din.vld && (din.port == NUM_PORT_BITS'(i)) && !queue_full[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < NUM_OUT_PORTS; k++) begin
                route_table[k] <= '0;
            end
        end else if (cfg_hit) begin
            route_table[din.addr[OUT_PORT_BITS-1:0]] <= '{
                en:   din.payload[CFG_EN_BIT],
                leaf: din.payload[CFG_LEAF_LSB +: NUM_LEAF_BITS],
                port: din.payload[CFG_PORT_LSB +: NUM_PORT_BITS]
            };
        end
    end

endmodule

`default_nettype wire

/* leaf_i4o7.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_i4o7 (
    input  wire                   clk,
    input  wire                   reset,
    input  leaf_pkg::bft_packet_t din_leaf_bft2interface,
    output leaf_pkg::bft_packet_t dout_leaf_interface2bft,
    input  wire                   resend,
    input  wire                   ap_start
);
    import leaf_pkg::*;

    wire                     reset_ap_start_user;
    user_word_t              dout_leaf_interface2user [NUM_IN_PORTS];
    wire [NUM_IN_PORTS-1:0]  vld_interface2user;
    wire [NUM_IN_PORTS-1:0]  ack_user2interface;
    user_word_t              din_leaf_user2interface [NUM_OUT_PORTS];
    wire [NUM_OUT_PORTS-1:0] vld_user2interface;
    wire [NUM_OUT_PORTS-1:0] ack_interface2user;

    leaf_interface i_leaf_interface (
        .clk                      (clk),
        .reset                    (reset),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2bft  (dout_leaf_interface2bft),
        .resend                   (resend),
        .ap_start                 (ap_start),
        .reset_ap_start_user      (reset_ap_start_user),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .vld_user2interface       (vld_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

    user_kernel i_user_kernel (
        .clk                      (clk),
        .reset                    (reset_ap_start_user),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

endmodule

`default_nettype wire

/* leaf_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_interface (
    input  wire                                 clk,
    input  wire                                 reset,
    input  leaf_pkg::bft_packet_t               din_leaf_bft2interface,
    output leaf_pkg::bft_packet_t               dout_leaf_interface2bft,
    input  wire                                 resend,
    input  wire                                 ap_start,
    output logic                                reset_ap_start_user,
    output leaf_pkg::user_word_t                dout_leaf_interface2user [leaf_pkg::NUM_IN_PORTS],
    output wire [leaf_pkg::NUM_IN_PORTS-1:0]    vld_interface2user,
    input  wire [leaf_pkg::NUM_IN_PORTS-1:0]    ack_user2interface,
    input  wire [leaf_pkg::NUM_OUT_PORTS-1:0]   vld_user2interface,
    input  leaf_pkg::user_word_t                din_leaf_user2interface [leaf_pkg::NUM_OUT_PORTS],
    output wire [leaf_pkg::NUM_OUT_PORTS-1:0]   ack_interface2user
);
    import leaf_pkg::*;

    bft_packet_t             arb_dout;
    route_t                  route_table [NUM_OUT_PORTS];
    user_word_t              in_data;
    wire [NUM_IN_PORTS-1:0]  in_push;
    wire [NUM_IN_PORTS-1:0]  in_pop;
    wire [NUM_IN_PORTS-1:0]  in_full;
    wire [NUM_IN_PORTS-1:0]  in_empty;
    user_word_t              in_head [NUM_IN_PORTS];
    wire [NUM_OUT_PORTS-1:0] out_push;
    wire [NUM_OUT_PORTS-1:0] out_pop;
    wire [NUM_OUT_PORTS-1:0] out_full;
    wire [NUM_OUT_PORTS-1:0] out_empty;
    user_word_t              out_word [NUM_OUT_PORTS];
    out_word_t               out_head [NUM_OUT_PORTS];
    user_word_t              out_head_word [NUM_OUT_PORTS];

    ingress_demux i_ingress_demux (
        .clk         (clk),
        .reset       (reset),
        .din         (din_leaf_bft2interface),
        .queue_full  (in_full),
        .queue_push  (in_push),
        .queue_data  (in_data),
        .route_table (route_table)
    );

    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_in
        stream_fifo #(.payload_t(user_word_t)) i_in_fifo (
            .clk       (clk),
            .reset     (reset),
            .push      (in_push[i]),
            .push_data (in_data),
            .pop       (in_pop[i]),
            .pop_data  (in_head[i]),
            .full      (in_full[i]),
            .empty     (in_empty[i])
        );

        user_port_bridge i_in_bridge (
            .clk        (clk),
            .reset      (reset),
            .to_user    (1'b1),
            .word_in    (in_head[i]),
            .word_avail (!in_empty[i]),
            .room       (1'b0),
            .vld_in     (1'b0),
            .ack_in     (ack_user2interface[i]),
            .word_out   (dout_leaf_interface2user[i]),
            .take       (in_pop[i]),
            .give       (),
            .vld_out    (vld_interface2user[i]),
            .ack_out    ()
        );
    end

    for (genvar j = 0; j < NUM_OUT_PORTS; j++) begin : g_out
        user_port_bridge i_out_bridge (
            .clk        (clk),
            .reset      (reset),
            .to_user    (1'b0),
            .word_in    (din_leaf_user2interface[j]),
            .word_avail (1'b0),
            .room       (!out_full[j]),   // full queue stalls the kernel
            .vld_in     (vld_user2interface[j]),
            .ack_in     (1'b0),
            .word_out   (out_word[j]),
            .take       (),
            .give       (out_push[j]),
            .vld_out    (),
            .ack_out    (ack_interface2user[j])
        );

        stream_fifo #(.payload_t(out_word_t)) i_out_fifo (
            .clk       (clk),
            .reset     (reset),
            .push      (out_push[j]),
            .push_data (out_word_t'{src: OUT_PORT_BITS'(j), word: out_word[j]}),
            .pop       (out_pop[j]),
            .pop_data  (out_head[j]),
            .full      (out_full[j]),
            .empty     (out_empty[j])
        );

        assign out_head_word[j] = out_head[j].word;
    end

    egress_arbiter i_egress_arbiter (
        .clk         (clk),
        .reset       (reset),
        .resend      (resend),
        .queue_empty (out_empty),
        .queue_head  (out_head_word),
        .route_table (route_table),
        .queue_pop   (out_pop),
        .dout        (arb_dout)
    );

    assign dout_leaf_interface2bft = resend ? '0 : arb_dout;

    // kernel stays in reset until the first ap_start
    always_ff @(posedge clk) begin
        if (reset) begin
            reset_ap_start_user <= 1'b1;
        end else if (ap_start) begin
            reset_ap_start_user <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* leaf_pkg.sv */
`default_nettype none

package leaf_pkg;

    localparam int PACKET_BITS    = 49;
    localparam int PAYLOAD_BITS   = 32;
    localparam int NUM_LEAF_BITS  = 5;
    localparam int NUM_PORT_BITS  = 4;
    localparam int NUM_ADDR_BITS  = 7;
    localparam int NUM_IN_PORTS   = 4;
    localparam int NUM_OUT_PORTS  = 7;
    localparam int OUT_PORT_BITS  = 3;   // index into the output ports
    localparam int QUEUE_DEPTH    = 16;
    localparam int QUEUE_PTR_BITS = 4;
    localparam int CONFIG_PORT    = 15;

    // payload fields of a configuration packet
    localparam int CFG_EN_BIT     = 31;
    localparam int CFG_LEAF_LSB   = 4;
    localparam int CFG_PORT_LSB   = 0;

    typedef logic [PAYLOAD_BITS-1:0] user_word_t;

    typedef struct packed {
        logic                     vld;
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
        logic [NUM_ADDR_BITS-1:0] addr;    // source output port, or route index in config
        user_word_t               payload;
    } bft_packet_t;

    typedef struct packed {
        logic                     en;
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
    } route_t;

    typedef struct packed {
        logic [OUT_PORT_BITS-1:0] src;
        user_word_t               word;
    } out_word_t;

endpackage

`default_nettype wire

/* stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = leaf_pkg::user_word_t
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      push,
    input  payload_t push_data,
    input  wire      pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);
    import leaf_pkg::*;

    payload_t                  mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_BITS-1:0] wr_ptr_q;
    logic [QUEUE_PTR_BITS-1:0] rd_ptr_q;
    logic [QUEUE_PTR_BITS:0]   count_q;
    logic                      do_push;
    logic                      do_pop;

    assign full     = (count_q == QUEUE_DEPTH);
    assign empty    = (count_q == '0);
    assign do_push  = push && !full;   // push while full is lost
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb_leaf_tasks.svh */
`ifndef TB_LEAF_TASKS_SVH
`define TB_LEAF_TASKS_SVH

function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic bft_packet_t data_packet(int port, logic [31:0] word);
    return bft_packet_t'{vld: 1'b1, leaf: 5'd3, port: 4'(port), addr: 7'd0, payload: word};
endfunction

// what the tree should see for a word leaving output port src
function automatic bft_packet_t result_packet(int src, logic [31:0] word);
    return bft_packet_t'{vld: 1'b1, leaf: route_leaf[src], port: route_port[src],
                         addr: 7'(src), payload: word};
endfunction

task automatic send_packet(bft_packet_t p);
    @(negedge clk);
    din = p;
    @(negedge clk);
    din = '0;
endtask

task automatic configure_route(int idx, logic en, logic [4:0] leaf, logic [3:0] port);
    send_packet(bft_packet_t'{vld: 1'b1, leaf: 5'd3, port: 4'd15, addr: 7'(idx),
                              payload: {en, 22'd0, leaf, port}});
    route_en[idx]   = en;
    route_leaf[idx] = leaf;
    route_port[idx] = port;
endtask

task automatic send_word(int i, output logic [31:0] w);
    w = next_random();
    send_packet(data_packet(i, w));
endtask

// data result on port i, count on port 4+i for the first three inputs
task automatic expect_word(int i, logic [31:0] w);
    accepted[i]++;
    if (route_en[i]) begin
        exp_q.push_back(result_packet(i, w + 32'd1));
    end
    if (i < 3 && route_en[NUM_IN_PORTS + i]) begin
        exp_q.push_back(result_packet(NUM_IN_PORTS + i, 32'(accepted[i])));
    end
endtask

task automatic pulse_ap_start();
    @(negedge clk);
    ap_start = 1'b1;
    @(negedge clk);
    ap_start = 1'b0;
endtask

// order only matters within one source port
task automatic check_results(string name);
    int          waited;
    bft_packet_t e_port [$];
    bft_packet_t g_port [$];
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < DRAIN_LIMIT) begin
        @(posedge clk);
        waited++;
    end
    repeat (QUIET_CYCLES) @(posedge clk);
    for (int s = 0; s < NUM_OUT_PORTS; s++) begin
        e_port.delete();
        g_port.delete();
        foreach (exp_q[k]) begin
            if (exp_q[k].addr == s) begin
                e_port.push_back(exp_q[k]);
            end
        end
        foreach (got_q[k]) begin
            if (got_q[k].addr == s) begin
                g_port.push_back(got_q[k]);
            end
        end
        assert (g_port.size() == e_port.size()) else begin
            $display("%s: port %0d sent %0d packets where %0d were expected",
                     name, s, g_port.size(), e_port.size());
            other_errors++;
        end
        for (int k = 0; k < e_port.size() && k < g_port.size(); k++) begin
            assert (g_port[k] == e_port[k]) else begin
                $display("FAIL %0t: %s port %0d packet %0d is %h, expected %h",
                         $time, name, s, k, g_port[k], e_port[k]);
                value_errors++;
            end
        end
    end
    exp_q.delete();
    got_q.delete();
endtask

task automatic kernel_hold_test();
    logic [31:0] words [HOLD_WORDS];
    configure_route(2, 1'b1, 5'd9, 4'd1);
    for (int k = 0; k < HOLD_WORDS; k++) begin
        send_word(2, words[k]);
    end
    repeat (QUIET_CYCLES) @(posedge clk);
    assert (got_q.size() == 0) else begin
        $display("kernel hold: %0d packets came out before ap_start", got_q.size());
        other_errors++;
    end
    pulse_ap_start();
    for (int k = 0; k < QUEUE_DEPTH; k++) begin   // the rest overflowed the queue
        expect_word(2, words[k]);
    end
    check_results("kernel hold");
endtask

task automatic routing_test();
    logic [31:0] w;
    for (int i = 0; i < NUM_IN_PORTS; i++) begin
        configure_route(i, 1'b1, 5'(i + 4), 4'(i + 8));
    end
    pulse_ap_start();
    for (int k = 0; k < ROUTE_WORDS; k++) begin
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            send_word(i, w);
            expect_word(i, w);
        end
    end
    check_results("routing");
endtask

task automatic counter_test();
    logic [31:0] w;
    for (int i = 0; i < 3; i++) begin
        configure_route(NUM_IN_PORTS + i, 1'b1, 5'(20 + i), 4'(i));
    end
    for (int k = 0; k < COUNT_WORDS; k++) begin
        for (int i = 0; i < 3; i++) begin
            send_word(i, w);
            expect_word(i, w);
        end
    end
    check_results("counters");
endtask

task automatic resend_test();
    logic [31:0] w;
    int          seen;
    @(negedge clk);
    resend = 1'b1;
    for (int k = 0; k < RESEND_WORDS; k++) begin
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            send_word(i, w);
            expect_word(i, w);
        end
    end
    repeat (QUIET_CYCLES) @(posedge clk);
    assert (got_q.size() == 0) else begin
        $display("resend: %0d packets got out while resend was high", got_q.size());
        other_errors++;
    end
    @(negedge clk);
    resend = 1'b0;
    // pause again mid drain so a registered packet has to wait
    while (got_q.size() == 0) begin
        @(negedge clk);
    end
    resend = 1'b1;
    seen   = got_q.size();
    repeat (QUIET_CYCLES) @(posedge clk);
    assert (got_q.size() == seen) else begin
        $display("resend: %0d packets got out during the second pause",
                 got_q.size() - seen);
        other_errors++;
    end
    @(negedge clk);
    resend = 1'b0;
    check_results("resend");
endtask

task automatic reconfig_test();
    logic [31:0] w;
    for (int p = 4; p < 15; p++) begin
        send_packet(bft_packet_t'{vld: 1'b1, leaf: 5'd3, port: 4'(p),
                                  addr: 7'(p % NUM_OUT_PORTS), payload: next_random()});
    end
    check_results("invalid ports");
    configure_route(0, 1'b1, 5'd30, 4'd13);
    for (int k = 0; k < RECONF_WORDS; k++) begin
        send_word(0, w);
        expect_word(0, w);
    end
    check_results("reconfiguration");
endtask

`endif

/* tb_leaf.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_leaf;
    import leaf_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 5;
    localparam int HOLD_WORDS    = 20;
    localparam int ROUTE_WORDS   = 8;    // per input port
    localparam int COUNT_WORDS   = 6;    // per counted input
    localparam int RESEND_WORDS  = 8;
    localparam int INVALID_PKTS  = 11;
    localparam int RECONF_WORDS  = 4;
    localparam int CONFIG_PKTS   = 9;
    localparam int TOTAL_PACKETS = HOLD_WORDS + 4 * ROUTE_WORDS + 3 * COUNT_WORDS
                                   + 4 * RESEND_WORDS + INVALID_PKTS + RECONF_WORDS
                                   + CONFIG_PKTS;
    localparam int LIMIT_CYCLES  = TOTAL_PACKETS * 200 + 2000;
    localparam int DRAIN_LIMIT   = 3000;
    localparam int QUIET_CYCLES  = 60;   // window to catch extra packets

    logic        clk;
    logic        reset;
    logic        resend;
    logic        ap_start;
    bft_packet_t din;
    bft_packet_t dout;

    bft_packet_t got_q [$];
    bft_packet_t exp_q [$];
    logic        route_en   [NUM_OUT_PORTS];
    logic [4:0]  route_leaf [NUM_OUT_PORTS];
    logic [3:0]  route_port [NUM_OUT_PORTS];
    int          accepted   [NUM_IN_PORTS];   // words taken by the kernel since its reset
    logic [31:0] rng_state;
    int          value_errors;
    int          other_errors;

    leaf_i4o7 i_leaf_i4o7 (
        .clk                     (clk),
        .reset                   (reset),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    `include "tb_leaf_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // tree side monitor
    always @(posedge clk) begin
        if (!reset) begin
            if (resend) begin
                assert (dout == '0) else begin
                    $display("FAIL %0t: tree output %h during resend", $time, dout);
                    value_errors++;
                end
            end
            if (dout.vld) begin
                assert (dout.addr < NUM_OUT_PORTS && route_en[dout.addr[2:0]]) else begin
                    $display("FAIL %0t: packet from unrouted port %0d", $time, dout.addr);
                    value_errors++;
                end
                got_q.push_back(dout);
            end
        end
    end

    initial begin
        #(CLK_PERIOD * LIMIT_CYCLES);
        $display("timeout: tests still running after %0d cycles", LIMIT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        resend       = 1'b0;
        ap_start     = 1'b0;
        din          = '0;
        rng_state    = 32'd84527;
        value_errors = 0;
        other_errors = 0;
        for (int k = 0; k < NUM_OUT_PORTS; k++) begin
            route_en[k]   = 1'b0;
            route_leaf[k] = '0;
            route_port[k] = '0;
        end
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            accepted[i] = 0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        kernel_hold_test();
        routing_test();
        counter_test();
        resend_test();
        reconfig_test();

        $display("errors: %0d wrong value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* user_kernel.sv */
`timescale 1ns/1ps
`default_nettype none

module user_kernel (
    input  wire                                 clk,
    input  wire                                 reset,
    input  leaf_pkg::user_word_t                dout_leaf_interface2user [leaf_pkg::NUM_IN_PORTS],
    input  wire [leaf_pkg::NUM_IN_PORTS-1:0]    vld_interface2user,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]   ack_user2interface,
    output leaf_pkg::user_word_t                din_leaf_user2interface [leaf_pkg::NUM_OUT_PORTS],
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]  vld_user2interface,
    input  wire [leaf_pkg::NUM_OUT_PORTS-1:0]   ack_interface2user
);
    import leaf_pkg::*;

    logic [NUM_OUT_PORTS-1:0] snd_rel_q;   // sender waits for ack low
    logic [NUM_OUT_PORTS-1:0] snd_idle;
    logic [NUM_OUT_PORTS-1:0] start;
    user_word_t               start_data [NUM_OUT_PORTS];
    user_word_t               count_q [NUM_OUT_PORTS-NUM_IN_PORTS];
    logic [NUM_OUT_PORTS-NUM_IN_PORTS-1:0] cnt_pend_q;
    logic [NUM_IN_PORTS-1:0]  busy;
    logic [NUM_IN_PORTS-1:0]  accept;

    always_comb begin
        snd_idle = ~vld_user2interface & ~snd_rel_q;
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            busy[i] = !snd_idle[i];
        end
        for (int i = 0; i < NUM_OUT_PORTS - NUM_IN_PORTS; i++) begin
            busy[i] = busy[i] || cnt_pend_q[i] || !snd_idle[NUM_IN_PORTS+i];
        end
        for (int i = 0; i < NUM_IN_PORTS; i++) begin
            accept[i]     = vld_interface2user[i] && !ack_user2interface[i] && !busy[i];
            start[i]      = accept[i];
            start_data[i] = dout_leaf_interface2user[i] + 1'b1;
        end
        // count goes out once the data result is through
        for (int i = 0; i < NUM_OUT_PORTS - NUM_IN_PORTS; i++) begin
            start[NUM_IN_PORTS+i]      = cnt_pend_q[i] && snd_idle[i];
            start_data[NUM_IN_PORTS+i] = count_q[i];
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_OUT_PORTS; k++) begin
            if (start[k]) begin
                din_leaf_user2interface[k] <= start_data[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_user2interface <= '0;
            snd_rel_q          <= '0;
            ack_user2interface <= '0;
            cnt_pend_q         <= '0;
            for (int i = 0; i < NUM_OUT_PORTS - NUM_IN_PORTS; i++) begin
                count_q[i] <= '0;
            end
        end else begin
            for (int k = 0; k < NUM_OUT_PORTS; k++) begin
                if (start[k]) begin
                    vld_user2interface[k] <= 1'b1;
                end else if (vld_user2interface[k] && ack_interface2user[k]) begin
                    vld_user2interface[k] <= 1'b0;
                    snd_rel_q[k]          <= 1'b1;
                end else if (snd_rel_q[k] && !ack_interface2user[k]) begin
                    snd_rel_q[k] <= 1'b0;
                end
            end
            for (int i = 0; i < NUM_IN_PORTS; i++) begin
                if (accept[i]) begin
                    ack_user2interface[i] <= 1'b1;
                end else if (ack_user2interface[i] && !vld_interface2user[i]) begin
                    ack_user2interface[i] <= 1'b0;
                end
            end
            for (int i = 0; i < NUM_OUT_PORTS - NUM_IN_PORTS; i++) begin
                if (accept[i]) begin
                    count_q[i]    <= count_q[i] + 1'b1;
                    cnt_pend_q[i] <= 1'b1;
                end else if (start[NUM_IN_PORTS+i]) begin
                    cnt_pend_q[i] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* user_port_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module user_port_bridge (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  to_user,     // 1: queue to kernel, 0: kernel to queue
    input  leaf_pkg::user_word_t word_in,
    input  wire                  word_avail,
    input  wire                  room,
    input  wire                  vld_in,
    input  wire                  ack_in,
    output leaf_pkg::user_word_t word_out,
    output logic                 take,
    output logic                 give,
    output logic                 vld_out,
    output logic                 ack_out
);

    typedef enum logic [1:0] {
        IDLE,
        HANDSHAKE,   // our line is high
        RELEASE      // waiting for the far side to drop ack
    } state_t;

    state_t state_q;
    logic   line_q;

    // queue head is held until ack, kernel data is held until our ack
    assign word_out = word_in;
    assign vld_out  = to_user && line_q;
    assign ack_out  = !to_user && line_q;
    assign take     = to_user && (state_q == HANDSHAKE) && ack_in;
    assign give     = !to_user && (state_q == IDLE) && vld_in && room;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            line_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (to_user ? word_avail : (vld_in && room)) begin
                        line_q  <= 1'b1;
                        state_q <= HANDSHAKE;
                    end
                end
                HANDSHAKE: begin
                    if (to_user ? ack_in : !vld_in) begin
                        line_q  <= 1'b0;
                        state_q <= to_user ? RELEASE : IDLE;
                    end
                end
                RELEASE: begin
                    if (!ack_in) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
leaf_pkg.sv
stream_fifo.sv
ingress_demux.sv
egress_arbiter.sv
user_port_bridge.sv
leaf_interface.sv
user_kernel.sv
leaf_i4o7.sv
tb_leaf.sv
